// ==== ds_cfg.svh ====
// Sizes for the unsigned divide/sqrt unit; DS_DATA_W must stay even for the sqrt step count
`ifndef DS_CFG_SVH
`define DS_CFG_SVH

// ------------------------------
// Datapath sizes
// ------------------------------
// Operand and result width in bits
`define DS_DATA_W 16

// Width of the tag carried with each operation
`define DS_TAG_W 4

// ------------------------------
// Elastic register stages
// ------------------------------
// Stages in front of the control FSM
`define DS_NUM_INP_REGS 1

// Stages behind the control FSM
`define DS_NUM_OUT_REGS 1

`endif

// ==== ds_op_pkg.sv ====
// Request side types; operand_b is carried but ignored by the unit for a square root
`include "ds_cfg.svh"

package ds_op_pkg;

  // ------------------------------
  // Operation select
  // ------------------------------
  // Single bit encoding
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } ds_op_e;

  // ------------------------------
  // Request payload
  // ------------------------------
  // Travels through the input stage into the control FSM
  // 2 x DS_DATA_W + 1 + DS_TAG_W bits
  typedef struct packed {
    // Dividend or radicand
    logic [`DS_DATA_W-1:0] operand_a;
    // Divisor
    logic [`DS_DATA_W-1:0] operand_b;
    // Which operation to run
    ds_op_e                op;
    // Handed back untouched with the response
    logic [`DS_TAG_W-1:0]  tag;
  } ds_req_t;

endpackage

// ==== ds_res_pkg.sv ====
// Response side types; a sqrt result sits in the low half of the result field
`include "ds_cfg.svh"

package ds_res_pkg;

  // ------------------------------
  // Status flags
  // ------------------------------
  typedef struct packed {
    // Divisor was zero
    logic div_zero;
    // Final remainder non-zero
    logic inexact;
  } ds_status_t;

  // ------------------------------
  // Response payload
  // ------------------------------
  // Leaves the control FSM into the output stage
  typedef struct packed {
    logic [`DS_DATA_W-1:0] result;
    ds_status_t            status;
    // Tag of the matching request
    logic [`DS_TAG_W-1:0]  tag;
  } ds_resp_t;

endpackage

// ==== ds_unit_if.sv ====
// Control to datapath link; result and status are only meaningful in the done cycle
`timescale 1ns/1ns
`include "ds_cfg.svh"

interface ds_unit_if;

  // ------------------------------
  // Control side
  // ------------------------------
  // One-cycle start strobes, never both at once
  logic                   div_start;
  logic                   sqrt_start;
  logic [`DS_DATA_W-1:0]  operand_a;
  logic [`DS_DATA_W-1:0]  operand_b;
  // Abort whatever is running
  logic                   kill;

  // ------------------------------
  // Datapath side
  // ------------------------------
  logic [`DS_DATA_W-1:0]  result;
  ds_res_pkg::ds_status_t status;
  // High while no operation runs
  logic                   unit_ready;
  // Single cycle completion pulse
  logic                   done;

  // FSM view
  modport ctrl (
    output div_start, sqrt_start, operand_a, operand_b, kill,
    input  result, status, unit_ready, done
  );

  // Iterative datapath view
  modport unit (
    input  div_start, sqrt_start, operand_a, operand_b, kill,
    output result, status, unit_ready, done
  );

endinterface

// ==== ds_pipe_regs.sv ====
// Elastic valid/ready chain; flush drops all stages and the input beat of that cycle
`timescale 1ns/1ns

module ds_pipe_regs #(
  parameter type         payload_t = logic,
  parameter int unsigned num_regs  = 1
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream handshake
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream handshake
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  // Any stage occupied
  output logic     busy_o
);

  // Index i holds the signal after i stages and index 0 is the input
  logic     valid_q [0:num_regs];
  logic     ready   [0:num_regs];
  payload_t data_q  [0:num_regs];

  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = in_data_i;
  assign in_ready_o = ready[0];

  // ------------------------------
  // Register stages
  // ------------------------------
  for (genvar i = 0; i < num_regs; i++) begin : gen_stage
    logic load;

    // Pass ready back when the next stage is empty
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Capture payload only for a real beat
    assign load     = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload register
    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Last stage faces downstream
  assign ready[num_regs] = out_ready_i;
  assign out_valid_o     = valid_q[num_regs];
  assign out_data_o      = data_q[num_regs];

  // OR of stage valids which stays zero with no stages
  always_comb begin : busy_reduce
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= num_regs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // A stalled beat stays put until taken
  property p_stall_stable;
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(out_data_o));
  endproperty
  a_stall_stable: assert property (p_stall_stable);

endmodule

// ==== ds_iter_unit.sv ====
// Restoring divide (DS_DATA_W cycles) and isqrt (DS_DATA_W/2 cycles); start ignored while busy
`timescale 1ns/1ns
`include "ds_cfg.svh"

module ds_iter_unit (
  input logic      clk_i,
  input logic      rst_n_i,
  ds_unit_if.unit  unit
);

  localparam int unsigned W     = `DS_DATA_W;
  // Partial remainder needs two guard bits for the sqrt trial
  localparam int unsigned RW    = W + 2;
  localparam int unsigned CNT_W = $clog2(W);

  // Control state
  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  logic             start;

  // Payload registers
  logic [RW-1:0] rem_q;
  logic [W-1:0]  shreg_q;
  logic [W-1:0]  res_q;
  logic [W-1:0]  divisor_q;
  logic          sqrt_q;
  logic          dz_q;

  // Step inputs and outputs
  logic [RW-1:0] st_rem;
  logic [W-1:0]  st_shreg;
  logic [W-1:0]  st_res;
  logic [W-1:0]  st_divisor;
  logic          st_sqrt;
  logic [RW-1:0] part_rem;
  logic [RW-1:0] trial;
  logic          fits;
  logic [RW-1:0] nxt_rem;
  logic [W-1:0]  nxt_shreg;
  logic [W-1:0]  nxt_res;

  ds_res_pkg::ds_status_t status;

  // Kill wins over a start in the same cycle
  assign start = (unit.div_start | unit.sqrt_start) & ~busy_q & ~unit.kill;

  // ------------------------------
  // One shift-subtract step
  // ------------------------------
  // The start cycle already runs step one on the fresh operands
  always_comb begin : step_inputs
    if (start) begin
      st_rem     = '0;
      st_shreg   = unit.operand_a;
      st_res     = '0;
      st_divisor = unit.operand_b;
      st_sqrt    = unit.sqrt_start;
    end else begin
      st_rem     = rem_q;
      st_shreg   = shreg_q;
      st_res     = res_q;
      st_divisor = divisor_q;
      st_sqrt    = sqrt_q;
    end
  end

  always_comb begin : step_calc
    if (st_sqrt) begin
      // Bring down two radicand bits and try root*4+1
      part_rem = {st_rem[RW-3:0], st_shreg[W-1 -: 2]};
      trial    = {st_res, 2'b01};
    end else begin
      // Bring down one dividend bit and try the divisor
      part_rem = {st_rem[RW-2:0], st_shreg[W-1]};
      trial    = {2'b00, st_divisor};
    end
    fits      = (part_rem >= trial);
    nxt_rem   = fits ? (part_rem - trial) : part_rem;
    nxt_res   = {st_res[W-2:0], fits};
    nxt_shreg = st_sqrt ? (st_shreg << 2) : (st_shreg << 1);
  end

  always_ff @(posedge clk_i) begin : datapath_regs
    if (start || busy_q) begin
      rem_q   <= nxt_rem;
      shreg_q <= nxt_shreg;
      res_q   <= nxt_res;
    end
    if (start) begin
      divisor_q <= unit.operand_b;
      sqrt_q    <= unit.sqrt_start;
      dz_q      <= unit.div_start & (unit.operand_b == '0);
    end
  end

  // ------------------------------
  // Step counter
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (unit.kill) begin
        busy_q <= 1'b0;
      end else if (start) begin
        busy_q <= 1'b1;
        // Steps left after the start cycle
        cnt_q  <= unit.sqrt_start ? CNT_W'(W/2 - 1) : CNT_W'(W - 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Zero divisor gives all ones naturally and leaves a as the remainder
  assign status.div_zero = dz_q;
  assign status.inexact  = |rem_q;

  assign unit.result     = res_q;
  assign unit.status     = status;
  assign unit.unit_ready = ~busy_q;
  assign unit.done       = done_q;

  // ------------------------------
  // Checks
  // ------------------------------
  a_one_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(unit.div_start && unit.sqrt_start));

  // Done closes an operation started one full step count earlier
  a_done_after_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit.done |-> ($past(start && unit.div_start, W)
      || $past(start && unit.sqrt_start, W/2)));

endmodule

// ==== ds_ctrl.sv ====
// One operation in flight; flush kills the unit and drops a held result in the same cycle
`timescale 1ns/1ns
`include "ds_cfg.svh"

module ds_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  // Request from the input stage
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  ds_op_pkg::ds_req_t    req_i,
  // Response to the output stage
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output ds_res_pkg::ds_resp_t  resp_o,
  // Operation in flight
  output logic                  busy_o,
  ds_unit_if.ctrl               unit
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e state_q, state_d;
  logic   accept;
  logic   hold_en;
  logic   held_q;

  // Side information of the running operation
  logic [`DS_TAG_W-1:0]   tag_q;
  // Parked result while downstream stalls
  logic [`DS_DATA_W-1:0]  held_result_q;
  ds_res_pkg::ds_status_t held_status_q;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin : fsm_comb
    state_d      = state_q;
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    busy_o       = 1'b0;
    unique case (state_q)
      IDLE: begin
        req_ready_o = unit.unit_ready;
        if (req_valid_i && unit.unit_ready) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        if (unit.done) begin
          resp_valid_o = 1'b1;
          if (resp_ready_i) begin
            // Result gone, next request may start right away
            state_d     = IDLE;
            req_ready_o = unit.unit_ready;
            if (req_valid_i && unit.unit_ready) begin
              state_d = BUSY;
            end
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o       = 1'b1;
        resp_valid_o = 1'b1;
        if (resp_ready_i) begin
          state_d     = IDLE;
          req_ready_o = unit.unit_ready;
          if (req_valid_i && unit.unit_ready) begin
            state_d = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush overrides everything
    if (flush_i) begin
      req_ready_o  = 1'b0;
      resp_valid_o = 1'b0;
      busy_o       = 1'b0;
      state_d      = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : fsm_reg
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // Datapath launch
  // ------------------------------
  assign accept          = req_valid_i & req_ready_o;
  assign unit.div_start  = accept & (req_i.op == ds_op_pkg::OP_DIV);
  assign unit.sqrt_start = accept & (req_i.op == ds_op_pkg::OP_SQRT);
  assign unit.operand_a  = req_i.operand_a;
  assign unit.operand_b  = req_i.operand_b;
  assign unit.kill       = flush_i;

  // Tag follows the operation it was started with
  always_ff @(posedge clk_i) begin : tag_reg
    if (accept) begin
      tag_q <= req_i.tag;
    end
  end

  // ------------------------------
  // Hold register
  // ------------------------------
  assign hold_en = (state_q == BUSY) & unit.done & ~resp_ready_i & ~flush_i;

  always_ff @(posedge clk_i) begin : hold_regs
    if (hold_en) begin
      held_result_q <= unit.result;
      held_status_q <= unit.status;
    end
  end

  // Marks a parked result
  always_ff @(posedge clk_i or negedge rst_n_i) begin : held_flag
    if (!rst_n_i) begin
      held_q <= 1'b0;
    end else if (hold_en) begin
      held_q <= 1'b1;
    end else if (flush_i || (state_q == HOLD && resp_ready_i)) begin
      held_q <= 1'b0;
    end
  end

  // Parked copy has priority over the live unit output
  assign resp_o.result = (state_q == HOLD) ? held_result_q : unit.result;
  assign resp_o.status = (state_q == HOLD) ? held_status_q : unit.status;
  assign resp_o.tag    = tag_q;

  a_hold_has_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == HOLD) |-> held_q);

endmodule

// ==== ds_top.sv ====
// Divide/sqrt wrapper; latency varies per op, responses stay in order, flush drops all in flight
`timescale 1ns/1ns
`include "ds_cfg.svh"

module ds_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  // Request
  input  logic [`DS_DATA_W-1:0]         operand_a_i,
  input  logic [`DS_DATA_W-1:0]         operand_b_i,
  input  ds_op_pkg::ds_op_e             op_i,
  input  logic [`DS_TAG_W-1:0]          tag_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  // Response
  output logic [`DS_DATA_W-1:0]         result_o,
  output ds_res_pkg::ds_status_t        status_o,
  output logic [`DS_TAG_W-1:0]          tag_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  // Data in flight anywhere
  output logic                          busy_o
);

  ds_op_pkg::ds_req_t   req_in, req_q;
  ds_res_pkg::ds_resp_t resp_d, resp_q;
  logic                 req_valid, req_ready;
  logic                 resp_valid, resp_ready;
  logic                 inp_busy, ctrl_busy, out_busy;

  // Pack the request
  assign req_in.operand_a = operand_a_i;
  assign req_in.operand_b = operand_b_i;
  assign req_in.op        = op_i;
  assign req_in.tag       = tag_i;

  // ------------------------------
  // Input stage
  // ------------------------------
  ds_pipe_regs #(
    .payload_t (ds_op_pkg::ds_req_t),
    .num_regs  (`DS_NUM_INP_REGS)
  ) u_inp_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (req_in),
    .out_valid_o (req_valid),
    .out_ready_i (req_ready),
    .out_data_o  (req_q),
    .busy_o      (inp_busy)
  );

  // ------------------------------
  // Control and datapath
  // ------------------------------
  ds_unit_if unit_if ();

  ds_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req_q),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_o       (resp_d),
    .busy_o       (ctrl_busy),
    .unit         (unit_if.ctrl)
  );

  ds_iter_unit u_iter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .unit    (unit_if.unit)
  );

  // ------------------------------
  // Output stage
  // ------------------------------
  ds_pipe_regs #(
    .payload_t (ds_res_pkg::ds_resp_t),
    .num_regs  (`DS_NUM_OUT_REGS)
  ) u_out_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (resp_valid),
    .in_ready_o  (resp_ready),
    .in_data_i   (resp_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (resp_q),
    .busy_o      (out_busy)
  );

  // Unpack the response
  assign result_o = resp_q.result;
  assign status_o = resp_q.status;
  assign tag_o    = resp_q.tag;

  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

// ==== tb_clkgen.sv ====
// Free running testbench clock, 20 ns period, starts low at time zero
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int unsigned half_period = 10
) (
  output logic clk_o
);

  initial begin : clk_init
    clk_o = 1'b0;
  end

  // Toggle every half period
  always #(half_period) clk_o = ~clk_o;

endmodule

// ==== tb_ds_top.sv ====
// Random divide/sqrt traffic with stalls and flushes; assumes DS_DATA_W <= 30 for the model
`timescale 1ns/1ns
`include "ds_cfg.svh"

module tb_ds_top;

  localparam int unsigned W            = `DS_DATA_W;
  localparam int unsigned T            = `DS_TAG_W;
  localparam int unsigned RESET_CYCLES = 8;
  // Operation counts per phase
  localparam int unsigned NUM_RANDOM   = 120;
  localparam int unsigned NUM_BURSTS   = 2;
  localparam int unsigned BURST_OPS    = 6;
  localparam int unsigned LONG_STALL   = 60;
  localparam int unsigned NUM_FLUSHES  = 4;
  localparam int unsigned FLUSH_OPS    = 3;
  localparam int unsigned NUM_RECOVERY = 24;
  localparam int unsigned NUM_OPS      = NUM_RANDOM + NUM_BURSTS * BURST_OPS
                                       + NUM_FLUSHES * FLUSH_OPS + NUM_RECOVERY;
  localparam int unsigned TIMEOUT_CYCLES = NUM_OPS * (W + 8) + RESET_CYCLES;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   flush_i;
  logic [W-1:0]           operand_a_i;
  logic [W-1:0]           operand_b_i;
  ds_op_pkg::ds_op_e      op_i;
  logic [T-1:0]           tag_i;
  logic                   in_valid_i;
  logic                   in_ready_o;
  logic [W-1:0]           result_o;
  ds_res_pkg::ds_status_t status_o;
  logic [T-1:0]           tag_o;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic                   busy_o;

  // One LFSR state per driving process
  logic [15:0] stim_state  = 16'd94;
  logic [15:0] stall_state = 16'd94;

  // Scoreboard
  ds_res_pkg::ds_resp_t   exp_q [$];
  ds_res_pkg::ds_resp_t   req_model;
  logic                   in_fire_seen  = 1'b0;
  logic                   out_fire_seen = 1'b0;
  logic                   flush_seen    = 1'b0;
  logic                   front_valid   = 1'b0;
  logic [W-1:0]           front_result  = '0;
  ds_res_pkg::ds_status_t front_status  = '0;
  logic [T-1:0]           front_tag     = '0;

  int unsigned cycle_count    = 0;
  int unsigned stall_until    = 0;
  int unsigned checked_count  = 0;
  int unsigned mismatch_count = 0;
  int unsigned failure_count  = 0;
  logic [T-1:0] next_tag      = '0;

  tb_clkgen u_clkgen (.clk_o(clk_i));

  ds_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // ------------------------------
  // Random source
  // ------------------------------
  // Galois form with taps at 16 14 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [W-1:0] take_stim_bits(input int unsigned n);
    logic [W-1:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      stim_state = lfsr_step(stim_state);
      v = {v[W-2:0], stim_state[0]};
    end
    return v;
  endfunction

  function automatic logic [1:0] take_stall_bits();
    logic [1:0] v;
    stall_state = lfsr_step(stall_state);
    v[0] = stall_state[0];
    stall_state = lfsr_step(stall_state);
    v[1] = stall_state[0];
    return v;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic ds_res_pkg::ds_resp_t model_response(input logic [W-1:0] a,
      input logic [W-1:0] b, input ds_op_pkg::ds_op_e op, input logic [T-1:0] tag);
    ds_res_pkg::ds_resp_t r;
    int unsigned root;
    r.tag = tag;
    r.status.div_zero = 1'b0;
    if (op == ds_op_pkg::OP_SQRT) begin
      // Largest root whose square still fits
      root = 0;
      for (int unsigned k = 0; k < (1 << (W / 2)); k++) begin
        if (k * k <= a) root = k;
      end
      r.result = W'(root);
      r.status.inexact = (root * root != a);
    end else if (b == '0) begin
      // Remainder is the whole dividend
      r.result = '1;
      r.status.div_zero = 1'b1;
      r.status.inexact = (a != '0);
    end else begin
      r.result = a / b;
      r.status.inexact = ((a % b) != '0);
    end
    return r;
  endfunction

  // ------------------------------
  // Error bookkeeping and end of run
  // ------------------------------
  task automatic note_mismatch(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    mismatch_count++;
    $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic note_failure(input string what);
    failure_count++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  task automatic finish_run();
    $display("Summary: %0d responses checked, %0d mismatches, %0d other errors",
      checked_count, mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // ------------------------------
  // Scoreboard
  // ------------------------------
  // Handshakes seen mid-cycle once inputs and registers have settled
  always @(negedge clk_i) begin : sample_handshakes
    in_fire_seen  = in_valid_i && in_ready_o;
    out_fire_seen = out_valid_o && out_ready_i;
    flush_seen    = flush_i;
    req_model     = model_response(operand_a_i, operand_b_i, op_i, tag_i);
  end

  always @(posedge clk_i or negedge rst_n_i) begin : scoreboard
    if (!rst_n_i) begin
      exp_q.delete();
    end else if (flush_seen) begin
      // Nothing in flight survives a flush
      exp_q.delete();
    end else begin
      if (out_fire_seen && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        checked_count++;
      end
      if (in_fire_seen) exp_q.push_back(req_model);
    end
    front_valid = (exp_q.size() > 0);
    if (front_valid) begin
      front_result = exp_q[0].result;
      front_status = exp_q[0].status;
      front_tag    = exp_q[0].tag;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && out_ready_i) |-> front_valid)
    else note_failure("response delivered with no request pending");

  a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && out_ready_i && front_valid) |-> (result_o == front_result))
    else note_mismatch("result_o", $sampled(result_o), $sampled(front_result));

  a_status: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && out_ready_i && front_valid) |-> (status_o == front_status))
    else note_mismatch("status_o", $sampled(status_o), $sampled(front_status));

  // Tag order doubles as the request order check
  a_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && out_ready_i && front_valid) |-> (tag_o == front_tag))
    else note_mismatch("tag_o", $sampled(tag_o), $sampled(front_tag));

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(result_o)
      && $stable(status_o) && $stable(tag_o)))
    else note_failure("response changed or vanished while output was stalled");

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> (!out_valid_o && !busy_o))
    else note_failure("output valid or busy still high the cycle after flush");

  a_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!out_valid_o && !busy_o && in_ready_o))
    else note_failure("wrong idle state of the handshake right after reset");

  // ------------------------------
  // Timeout and output back-pressure
  // ------------------------------
  always @(posedge clk_i) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      note_failure("timeout, run did not finish in time");
      finish_run();
    end
  end

  // Ready three quarters of the time unless held low for a long stall
  always @(posedge clk_i) begin : drive_out_ready
    if (rst_n_i) begin
      if (cycle_count < stall_until) begin
        out_ready_i <= 1'b0;
      end else begin
        out_ready_i <= (take_stall_bits() != 2'b00);
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  // Called right after a rising edge and returns on the handshake edge
  task automatic issue_request(input logic [W-1:0] a, input logic [W-1:0] b,
      input ds_op_pkg::ds_op_e op);
    operand_a_i <= a;
    operand_b_i <= b;
    op_i        <= op;
    tag_i       <= next_tag;
    in_valid_i  <= 1'b1;
    next_tag = next_tag + 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic random_request();
    logic [W-1:0]      a;
    logic [W-1:0]      b;
    logic [1:0]        sel;
    ds_op_pkg::ds_op_e op;
    op  = take_stim_bits(1) ? ds_op_pkg::OP_SQRT : ds_op_pkg::OP_DIV;
    sel = take_stim_bits(2);
    a   = take_stim_bits(W);
    b   = take_stim_bits(W);
    // Steer a share of the traffic into corner cases
    if (sel == 2'd0 && op == ds_op_pkg::OP_DIV) b = '0;
    if (sel == 2'd0 && op == ds_op_pkg::OP_SQRT) a = a[W/2-1:0] * a[W/2-1:0];
    if (sel == 2'd1) b = b & W'(4'hF);
    issue_request(a, b, op);
  endtask

  task automatic idle_cycles(input int unsigned n);
    in_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // Long output stall fills every stage
  task automatic stall_burst();
    stall_until <= cycle_count + LONG_STALL;
    for (int unsigned k = 0; k < BURST_OPS; k++) random_request();
    idle_cycles(1);
  endtask

  task automatic flush_midway();
    for (int unsigned k = 0; k < FLUSH_OPS; k++) random_request();
    idle_cycles(take_stim_bits(4));
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : stimulus
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = ds_op_pkg::OP_DIV;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    for (int unsigned i = 0; i < NUM_RANDOM; i++) begin
      random_request();
      if (take_stim_bits(1)) idle_cycles(take_stim_bits(2));
    end
    for (int unsigned i = 0; i < NUM_BURSTS; i++) stall_burst();
    for (int unsigned i = 0; i < NUM_FLUSHES; i++) flush_midway();
    // Work after the flushes must still come out right
    for (int unsigned i = 0; i < NUM_RECOVERY; i++) random_request();
    idle_cycles(0);
    @(negedge clk_i);
    while (front_valid || busy_o || out_valid_o) @(negedge clk_i);
    finish_run();
  end

endmodule

// ==== src.f ====
+incdir+.
ds_op_pkg.sv
ds_res_pkg.sv
ds_unit_if.sv
ds_pipe_regs.sv
ds_iter_unit.sv
ds_ctrl.sv
ds_top.sv
tb_clkgen.sv
tb_ds_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the divide/sqrt testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_ds_top -o sim_tb_ds_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_ds_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$output"; then
  exit 0
fi
exit 1
